// ==== design/spmv_cmd_pkg.sv ====
package spmv_cmd_pkg;

    typedef logic [63:0] op_word_t;

    // opcode sits in the low byte of every ring word
    typedef enum logic [7:0] {
        OP_NOP    = 8'd0,
        OP_RST    = 8'd1,
        OP_LD     = 8'd2,
        OP_READ   = 8'd3,
        OP_STEADY = 8'd4,
        OP_RETURN = 8'd5
    } op_e;

    // ring word field positions
    localparam int OPC_LSB   = 0;
    localparam int PE_LSB    = 8;
    localparam int PE_W      = 7;
    localparam int BCAST_BIT = 15;
    localparam int REGN_LSB  = 16;
    localparam int REGN_W    = 8;
    localparam int VAL_LSB   = 24;
    localparam int REG_W     = 40;

    typedef enum logic {
        ST_IDLE,
        ST_STEADY
    } run_state_e;

    localparam logic [REGN_W-1:0] REG_CODE_PTR = 8'd0;
    localparam logic [REGN_W-1:0] REG_ARG_PTR  = 8'd1;
    localparam logic [REGN_W-1:0] REG_CODE_END = 8'd2;
    localparam logic [REGN_W-1:0] REG_ARG_END  = 8'd3;
    localparam logic [REGN_W-1:0] REG_NNZ      = 8'd4;

endpackage

// ==== design/spmv_stream_pkg.sv ====
package spmv_stream_pkg;

    // byte addresses with word reads stepping by WORD_BYTES
    localparam int ADDR_W     = 40;
    localparam int WORD_W     = 64;
    localparam int WORD_BYTES = 8;

    typedef enum logic {
        TAG_CODE = 1'b0,
        TAG_ARG  = 1'b1
    } tag_e;

    // token layout has kind in [1:0] and delta in [6:2] with bit 7 spare
    typedef enum logic [1:0] {
        KIND_NEWLINE  = 2'd0,
        KIND_CONSTANT = 2'd1,
        KIND_RANGE    = 2'd2
    } token_kind_e;

    localparam int TOKEN_W         = 8;
    localparam int DELTA_W         = 5;
    localparam int TOKENS_PER_WORD = WORD_W / TOKEN_W;

    typedef logic [31:0] index_t;

endpackage

// ==== design/reg_if.sv ====
interface reg_if import spmv_cmd_pkg::*; ();

    logic             wr;
    // 0 picks the pointer and 1 the end address
    logic             sel;
    logic [REG_W-1:0] wdata;
    logic [REG_W-1:0] rdata;

    modport master (output wr, output sel, output wdata, input rdata);
    modport slave (input wr, input sel, input wdata, output rdata);

endinterface

// ==== design/op_decoder.sv ====
module op_decoder import spmv_cmd_pkg::*; #(
    parameter int PE_ID = 3
) (
    input  logic             clk,
    input  logic             rst,
    input  op_word_t         op_in,
    input  logic [REG_W-1:0] nnz_left,
    input  logic             code_done,
    input  logic             arg_done,
    output op_word_t         op_out,
    output logic             busy,
    output logic             running,
    output logic             flush,
    output logic             nnz_wr,
    output logic [REG_W-1:0] nnz_wdata,
    reg_if.master            code_reg,
    reg_if.master            arg_reg
);

    op_word_t          op_r;
    op_word_t          reply;
    op_e               opcode;
    logic [REGN_W-1:0] regn;
    logic [REG_W-1:0]  value;
    logic [REG_W-1:0]  read_data;
    logic              active;
    logic              is_ld;
    logic              read_ok;
    run_state_e        state;

    // ring word is decoded one cycle after it passes
    always_ff @(posedge clk) begin
        if (rst) begin
            op_r <= '0;
        end else begin
            op_r <= op_in;
        end
    end

    assign opcode = op_e'(op_r[OPC_LSB +: 8]);
    assign regn   = op_r[REGN_LSB +: REGN_W];
    assign value  = op_r[VAL_LSB +: REG_W];
    assign active = op_r[BCAST_BIT] || (op_r[PE_LSB +: PE_W] == PE_W'(PE_ID));
    assign is_ld  = active && (opcode == OP_LD);
    assign flush  = active && (opcode == OP_RST);

    // register number picks the fetcher port and its pointer/end select
    assign code_reg.sel   = (regn == REG_CODE_END);
    assign arg_reg.sel    = (regn == REG_ARG_END);
    assign code_reg.wr    = is_ld && (regn == REG_CODE_PTR || regn == REG_CODE_END);
    assign arg_reg.wr     = is_ld && (regn == REG_ARG_PTR || regn == REG_ARG_END);
    assign code_reg.wdata = value;
    assign arg_reg.wdata  = value;
    assign nnz_wr         = is_ld && (regn == REG_NNZ);
    assign nnz_wdata      = value;

    always_comb begin
        read_ok = 1'b1;
        case (regn)
            REG_CODE_PTR, REG_CODE_END: read_data = code_reg.rdata;
            REG_ARG_PTR, REG_ARG_END:   read_data = arg_reg.rdata;
            REG_NNZ:                    read_data = nnz_left;
            default: begin
                read_data = '0;
                read_ok   = 1'b0;
            end
        endcase
    end

    always_comb begin
        reply = '0;
        reply[OPC_LSB +: 8]       = OP_RETURN;
        reply[PE_LSB +: PE_W]     = PE_W'(PE_ID);
        reply[REGN_LSB +: REGN_W] = regn;
        reply[VAL_LSB +: REG_W]   = read_data;
    end

    // second stage of the two cycle read path
    always_ff @(posedge clk) begin
        if (rst) begin
            op_out <= '0;
        end else if (active && opcode == OP_READ && read_ok) begin
            op_out <= reply;
        end else begin
            op_out <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (active && opcode == OP_STEADY) begin
                        state <= ST_STEADY;
                    end
                end
                ST_STEADY: begin
                    if (code_done && arg_done && nnz_left == '0) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign busy    = (state == ST_STEADY);
    // fetchers stop on the soft reset cycle itself
    assign running = busy && !flush;

endmodule

// ==== design/stream_fetcher.sv ====
module stream_fetcher import spmv_stream_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              running,
    input  logic              grant,
    input  logic              credit_ret,
    output logic              req,
    output logic [ADDR_W-1:0] addr,
    output logic              done,
    reg_if.slave              regs
);

    localparam int CREDIT_W = $clog2(FIFO_DEPTH + 1);

    logic [ADDR_W-1:0]   ptr;
    logic [ADDR_W-1:0]   end_addr;
    logic [CREDIT_W-1:0] credit;

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr      <= '0;
            end_addr <= '0;
        end else if (regs.wr) begin
            if (regs.sel) begin
                end_addr <= regs.wdata;
            end else begin
                ptr <= regs.wdata;
            end
        end else if (grant) begin
            ptr <= ptr + ADDR_W'(WORD_BYTES);
        end
    end

    // one credit per free FIFO slot returned on every pop
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            credit <= CREDIT_W'(FIFO_DEPTH);
        end else if (grant && !credit_ret) begin
            credit <= credit - 1'b1;
        end else if (credit_ret && !grant) begin
            credit <= credit + 1'b1;
        end
    end

    assign done       = (ptr == end_addr);
    assign req        = running && !done && (credit != '0);
    assign addr       = ptr;
    assign regs.rdata = regs.sel ? end_addr : ptr;

endmodule

// ==== design/mem_arbiter.sv ====
module mem_arbiter import spmv_stream_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              code_req,
    input  logic [ADDR_W-1:0] code_addr,
    input  logic              arg_req,
    input  logic [ADDR_W-1:0] arg_addr,
    input  logic              req_mem_stall,
    output logic              code_grant,
    output logic              arg_grant,
    output logic              req_mem_ld,
    output logic [ADDR_W-1:0] req_mem_addr,
    output tag_e              req_mem_tag
);

    tag_e sel;
    tag_e held_sel;
    tag_e last_win;
    logic held;

    // a stalled request keeps its owner until it is taken
    always_comb begin
        if (held) begin
            sel = held_sel;
        end else if (code_req && arg_req) begin
            sel = (last_win == TAG_CODE) ? TAG_ARG : TAG_CODE;
        end else if (arg_req) begin
            sel = TAG_ARG;
        end else begin
            sel = TAG_CODE;
        end
    end

    assign req_mem_ld   = (sel == TAG_ARG) ? arg_req : code_req;
    assign req_mem_addr = (sel == TAG_ARG) ? arg_addr : code_addr;
    assign req_mem_tag  = sel;
    assign code_grant   = req_mem_ld && !req_mem_stall && (sel == TAG_CODE);
    assign arg_grant    = req_mem_ld && !req_mem_stall && (sel == TAG_ARG);

    always_ff @(posedge clk) begin
        held_sel <= sel;
        if (rst) begin
            held     <= 1'b0;
            last_win <= TAG_ARG;
        end else begin
            held <= req_mem_ld && req_mem_stall;
            if (code_grant || arg_grant) begin
                last_win <= sel;
            end
        end
    end

endmodule

// ==== design/word_fifo.sv ====
module word_fifo import spmv_stream_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              push,
    input  logic [WORD_W-1:0] data,
    input  logic              pop,
    output logic [WORD_W-1:0] q,
    output logic              empty
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [WORD_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    count;
    logic              do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_pop = pop && !empty;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + push - do_pop;
        end
    end

    // head word visible before the pop
    assign q     = mem[rd_ptr];
    assign empty = (count == '0);

endmodule

// ==== design/bit_unpacker.sv ====
module bit_unpacker import spmv_stream_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic [WORD_W-1:0]  word,
    input  logic               word_empty,
    input  logic [DELTA_W-1:0] pop_count,
    output logic               word_pop,
    output index_t             bits,
    output logic [6:0]         avail
);

    localparam int BUF_W = 2 * WORD_W;
    localparam int CNT_W = $clog2(BUF_W + 1);

    logic [BUF_W-1:0] buffer;
    logic [BUF_W-1:0] shifted;
    logic [CNT_W-1:0] held;
    logic [CNT_W-1:0] remain;

    // top up once half the buffer has drained
    assign word_pop = !word_empty && (held <= CNT_W'(WORD_W));

    always_comb begin
        shifted = buffer >> pop_count;
        remain  = held - CNT_W'(pop_count);
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            buffer <= '0;
            held   <= '0;
        end else if (word_pop) begin
            // new word lands just above the bits still held
            buffer <= shifted | ({{WORD_W{1'b0}}, word} << remain);
            held   <= remain + CNT_W'(WORD_W);
        end else begin
            buffer <= shifted;
            held   <= remain;
        end
    end

    assign bits = buffer[31:0];
    // a full buffer reads as 127 since the consumer needs at most 31
    assign avail = held[CNT_W-1] ? 7'd127 : held[6:0];

endmodule

// ==== design/index_accumulator.sv ====
module index_accumulator import spmv_cmd_pkg::*, spmv_stream_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               running,
    input  logic [WORD_W-1:0]  code_word,
    input  logic               code_empty,
    input  index_t             arg_bits,
    input  logic [6:0]         arg_avail,
    input  logic               nnz_wr,
    input  logic [REG_W-1:0]   nnz_wdata,
    input  logic               stall_index,
    output logic               code_pop,
    output logic [DELTA_W-1:0] arg_pop_count,
    output logic [REG_W-1:0]   nnz_left,
    output logic               push_index,
    output index_t             row,
    output index_t             col
);

    localparam int SLOT_W = $clog2(TOKENS_PER_WORD);

    logic [SLOT_W-1:0]  slot;
    logic [TOKEN_W-1:0] token;
    token_kind_e        kind;
    logic [DELTA_W-1:0] delta;
    logic               is_range;
    logic               consume;
    logic               emit;
    index_t             range_mask;
    index_t             step;
    logic [REG_W-1:0]   nnz;

    // tokens taken low byte first
    assign token    = code_word[slot*TOKEN_W +: TOKEN_W];
    assign kind     = token_kind_e'(token[1:0]);
    assign delta    = token[2 +: DELTA_W];
    assign is_range = (kind == KIND_RANGE);

    // a range token waits for its argument bits
    assign consume = running && !code_empty && !stall_index
                     && !(is_range && arg_avail < 7'(delta));
    assign code_pop      = consume && (slot == SLOT_W'(TOKENS_PER_WORD - 1));
    assign arg_pop_count = (consume && is_range) ? delta : '0;
    assign emit          = consume && (kind != KIND_NEWLINE) && (nnz != '0);
    assign nnz_left      = nnz;

    // spare kind 3 steps like a constant
    always_comb begin
        range_mask = (index_t'(1) << delta) - 1'b1;
        if (is_range) begin
            step = ((arg_bits & range_mask) | (index_t'(1) << delta)) + 1'b1;
        end else begin
            step = index_t'(delta) + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            slot       <= '0;
            row        <= '0;
            col        <= '1;
            push_index <= 1'b0;
        end else begin
            push_index <= emit;
            if (consume) begin
                slot <= slot + 1'b1;
                if (kind == KIND_NEWLINE) begin
                    row <= row + 1'b1;
                    col <= '1;
                end else begin
                    col <= col + step;
                end
            end
        end
    end

    // count survives the soft reset like the other registers
    always_ff @(posedge clk) begin
        if (rst) begin
            nnz <= '0;
        end else if (nnz_wr) begin
            nnz <= nnz_wdata;
        end else if (emit) begin
            nnz <= nnz - 1'b1;
        end
    end

endmodule

// ==== design/spmv_decoder_top.sv ====
module spmv_decoder_top import spmv_cmd_pkg::*, spmv_stream_pkg::*; #(
    parameter int PE_ID      = 3,
    parameter int FIFO_DEPTH = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  op_word_t          op_in,
    output op_word_t          op_out,
    output logic              busy,
    output logic              req_mem_ld,
    output logic [ADDR_W-1:0] req_mem_addr,
    output tag_e              req_mem_tag,
    input  logic              req_mem_stall,
    input  logic              rsp_mem_push,
    input  tag_e              rsp_mem_tag,
    input  logic [WORD_W-1:0] rsp_mem_q,
    output logic              push_index,
    output index_t            row,
    output index_t            col,
    input  logic              stall_index
);

    logic               running;
    logic               flush;
    logic               nnz_wr;
    logic [REG_W-1:0]   nnz_wdata;
    logic [REG_W-1:0]   nnz_left;
    logic               code_req, arg_req;
    logic [ADDR_W-1:0]  code_addr, arg_addr;
    logic               code_grant, arg_grant;
    logic               code_done, arg_done;
    logic               code_push, arg_push;
    logic [WORD_W-1:0]  code_q, arg_q;
    logic               code_empty, arg_empty;
    logic               code_pop, arg_word_pop;
    index_t             arg_bits;
    logic [6:0]         arg_avail;
    logic [DELTA_W-1:0] arg_pop_count;

    reg_if code_regs ();
    reg_if arg_regs ();

    // responses steered by tag
    assign code_push = rsp_mem_push && (rsp_mem_tag == TAG_CODE);
    assign arg_push  = rsp_mem_push && (rsp_mem_tag == TAG_ARG);

    op_decoder #(.PE_ID(PE_ID)) u_op_decoder (
        .clk(clk), .rst(rst), .op_in(op_in), .nnz_left(nnz_left),
        .code_done(code_done), .arg_done(arg_done), .op_out(op_out), .busy(busy),
        .running(running), .flush(flush), .nnz_wr(nnz_wr), .nnz_wdata(nnz_wdata),
        .code_reg(code_regs.master), .arg_reg(arg_regs.master)
    );

    stream_fetcher #(.FIFO_DEPTH(FIFO_DEPTH)) u_code_fetcher (
        .clk(clk), .rst(rst), .flush(flush), .running(running), .grant(code_grant),
        .credit_ret(code_pop), .req(code_req), .addr(code_addr), .done(code_done),
        .regs(code_regs.slave)
    );

    stream_fetcher #(.FIFO_DEPTH(FIFO_DEPTH)) u_arg_fetcher (
        .clk(clk), .rst(rst), .flush(flush), .running(running), .grant(arg_grant),
        .credit_ret(arg_word_pop), .req(arg_req), .addr(arg_addr), .done(arg_done),
        .regs(arg_regs.slave)
    );

    mem_arbiter u_mem_arbiter (
        .clk(clk), .rst(rst), .code_req(code_req), .code_addr(code_addr),
        .arg_req(arg_req), .arg_addr(arg_addr), .req_mem_stall(req_mem_stall),
        .code_grant(code_grant), .arg_grant(arg_grant), .req_mem_ld(req_mem_ld),
        .req_mem_addr(req_mem_addr), .req_mem_tag(req_mem_tag)
    );

    word_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_code_fifo (
        .clk(clk), .rst(rst), .flush(flush), .push(code_push), .data(rsp_mem_q),
        .pop(code_pop), .q(code_q), .empty(code_empty)
    );

    word_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_arg_fifo (
        .clk(clk), .rst(rst), .flush(flush), .push(arg_push), .data(rsp_mem_q),
        .pop(arg_word_pop), .q(arg_q), .empty(arg_empty)
    );

    bit_unpacker u_bit_unpacker (
        .clk(clk), .rst(rst), .flush(flush), .word(arg_q), .word_empty(arg_empty),
        .pop_count(arg_pop_count), .word_pop(arg_word_pop), .bits(arg_bits),
        .avail(arg_avail)
    );

    index_accumulator u_index_accumulator (
        .clk(clk), .rst(rst), .flush(flush), .running(running), .code_word(code_q),
        .code_empty(code_empty), .arg_bits(arg_bits), .arg_avail(arg_avail),
        .nnz_wr(nnz_wr), .nnz_wdata(nnz_wdata), .stall_index(stall_index),
        .code_pop(code_pop), .arg_pop_count(arg_pop_count), .nnz_left(nnz_left),
        .push_index(push_index), .row(row), .col(col)
    );

endmodule

// ==== sim/spmv_decoder_props.sv ====
module spmv_decoder_props import spmv_cmd_pkg::*, spmv_stream_pkg::*; (
    input logic              clk,
    input logic              rst,
    input logic              busy,
    input logic              req_mem_ld,
    input logic              req_mem_stall,
    input logic [ADDR_W-1:0] req_mem_addr,
    input tag_e              req_mem_tag,
    input op_word_t          op_out
);

    // a stalled read keeps its address and tag
    stable_req: assert property (@(posedge clk) disable iff (rst)
        req_mem_ld && req_mem_stall |=> $stable(req_mem_addr) && $stable(req_mem_tag))
        else $error("memory request changed while stalled");

    idle_no_req: assert property (@(posedge clk) disable iff (rst)
        !busy |-> !req_mem_ld)
        else $error("memory request while not busy");

    op_out_form: assert property (@(posedge clk) disable iff (rst)
        op_out == '0 || op_out[7:0] == OP_RETURN)
        else $error("op_out carries an opcode other than return");

endmodule

bind spmv_decoder_top spmv_decoder_props u_props (.*);

// ==== sim/spmv_decoder_tb.sv ====
module spmv_decoder_tb import spmv_cmd_pkg::*, spmv_stream_pkg::*; ;

    localparam int PE_ID      = 3;
    localparam int FIFO_DEPTH = 16;
    localparam int TIMEOUT    = 20000;
    localparam logic [ADDR_W-1:0] CODE_BASE = 40'h00_0010_0000;
    localparam logic [ADDR_W-1:0] ARG_BASE  = 40'h00_0020_0000;

    logic clk = 1'b0;
    logic rst, req_mem_ld, req_mem_stall, rsp_mem_push, push_index, stall_index, busy;
    op_word_t op_in, op_out;
    logic [ADDR_W-1:0] req_mem_addr;
    tag_e req_mem_tag, rsp_mem_tag;
    logic [WORD_W-1:0] rsp_mem_q;
    index_t row, col;

    logic [WORD_W-1:0] mem_words [logic [ADDR_W-1:0]];
    logic [WORD_W-1:0] code_words[$];
    logic [WORD_W-1:0] arg_words[$];
    tag_e pend_tag[$];
    logic [ADDR_W-1:0] pend_addr[$];
    int pend_due[$];
    index_t exp_row[$], exp_col[$], got_row[$], got_col[$];
    int cyc = 0;
    int tok_pushes;
    int range_bits;
    logic mem_flush = 1'b0;
    logic mem_stall_en = 1'b0;
    logic idx_stall_en = 1'b0;

    spmv_decoder_top #(.PE_ID(PE_ID), .FIFO_DEPTH(FIFO_DEPTH)) DUT (.*);

    always #50 clk = ~clk;

    function automatic logic [WORD_W-1:0] mem_read(input logic [ADDR_W-1:0] a);
        if (mem_words.exists(a)) begin
            return mem_words[a];
        end
        // untouched words depend on the full address
        return {a[23:0] ^ 24'ha5c3e1, a};
    endfunction

    // memory model accepts on the edge and answers 1-4 cycles later in order
    always @(posedge clk) begin
        cyc++;
        if (req_mem_ld && !req_mem_stall) begin
            pend_tag.push_back(req_mem_tag);
            pend_addr.push_back(req_mem_addr);
            pend_due.push_back(cyc + int'($urandom % 4));
        end
        if (mem_flush) begin
            pend_tag.delete();
            pend_addr.delete();
            pend_due.delete();
            mem_flush = 1'b0;
        end
        #1;
        req_mem_stall = mem_stall_en && ($urandom % 3 == 0);
        stall_index   = idx_stall_en && ($urandom % 3 == 0);
        if (pend_due.size() > 0 && pend_due[0] <= cyc) begin
            rsp_mem_push = 1'b1;
            rsp_mem_tag  = pend_tag.pop_front();
            rsp_mem_q    = mem_read(pend_addr.pop_front());
            void'(pend_due.pop_front());
        end else begin
            rsp_mem_push = 1'b0;
        end
    end

    always @(posedge clk) begin
        if (push_index) begin
            got_row.push_back(row);
            got_col.push_back(col);
        end
    end

    task automatic fail(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    function automatic op_word_t make_op(input op_e opc, input int pe, input logic bc,
                                         input logic [7:0] regn, input logic [39:0] val);
        return {val, regn, bc, pe[6:0], opc};
    endfunction

    task automatic send_op(input op_word_t w, input logic is_rst);
        op_in = w;
        if (is_rst) begin
            mem_flush = 1'b1;
        end
        @(posedge clk);
        #1;
        op_in = '0;
    endtask

    // reply shows up two edges after the command was driven
    task automatic check_read(input op_word_t cmd, input op_word_t expected);
        send_op(cmd, 1'b0);
        @(posedge clk);
        #1;
        assert (op_out == expected)
            else fail($sformatf("Error: op_out got %h expected %h", op_out, expected));
    endtask

    task automatic wait_busy(input logic level);
        int n;
        n = 0;
        while (busy !== level) begin
            @(posedge clk);
            #1;
            n++;
            assert (n < TIMEOUT) else fail($sformatf("busy never went to %0d", level));
        end
    endtask

    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            assert (!busy && !req_mem_ld && !push_index)
                else fail("decoder active while it should be idle");
            @(posedge clk);
            #1;
        end
    endtask

    function automatic logic [31:0] take_bits(input int pos, input int d);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < d; i++) begin
            v[i] = arg_words[(pos + i) / 64][(pos + i) % 64];
        end
        return v;
    endfunction

    // token rules applied to the same code and argument words
    task automatic build_model(input int nnz);
        index_t r, c;
        logic [7:0] tok;
        int pos, d;
        r = '0;
        c = '1;
        pos = 0;
        exp_row.delete();
        exp_col.delete();
        foreach (code_words[i]) begin
            for (int t = 0; t < 8; t++) begin
                tok = code_words[i][t*8 +: 8];
                d = int'(tok[6:2]);
                if (tok[1:0] == 2'd0) begin
                    r = r + 1;
                    c = '1;
                end else begin
                    if (tok[1:0] == 2'd2) begin
                        c = c + (take_bits(pos, d) | (32'd1 << d)) + 1;
                        pos += d;
                    end else begin
                        c = c + d + 1;
                    end
                    if (nnz > 0) begin
                        exp_row.push_back(r);
                        exp_col.push_back(c);
                        nnz--;
                    end
                end
            end
        end
    endtask

    task automatic gen_stream(input int words, input logic with_range);
        logic [WORD_W-1:0] w;
        int k;
        code_words.delete();
        arg_words.delete();
        tok_pushes = 0;
        range_bits = 0;
        for (int i = 0; i < words; i++) begin
            for (int t = 0; t < 8; t++) begin
                k = $urandom % 10;
                w[t*8 +: 8] = {1'b0, 5'($urandom % 32), 2'd1};
                if (k < 2) begin
                    w[t*8 +: 2] = 2'd0;
                end else if (with_range && k < 6) begin
                    w[t*8 +: 2] = 2'd2;
                    range_bits += int'(w[t*8+2 +: 5]);
                end
                if (w[t*8 +: 2] != 2'd0) begin
                    tok_pushes++;
                end
            end
            code_words.push_back(w);
        end
        for (int i = 0; i < range_bits / 64 + 1; i++) begin
            arg_words.push_back({$urandom, $urandom});
        end
    endtask

    task automatic start_stream(input logic [ADDR_W-1:0] cb, input logic [ADDR_W-1:0] ab,
                                input int nnz);
        send_op(make_op(OP_RST, PE_ID, 1'b0, 8'd0, '0), 1'b1);
        foreach (code_words[i]) mem_words[cb + 8 * i] = code_words[i];
        foreach (arg_words[i]) mem_words[ab + 8 * i] = arg_words[i];
        send_op(make_op(OP_LD, PE_ID, 1'b0, REG_CODE_PTR, cb), 1'b0);
        send_op(make_op(OP_LD, PE_ID, 1'b0, REG_CODE_END, cb + 8 * code_words.size()), 1'b0);
        send_op(make_op(OP_LD, PE_ID, 1'b0, REG_ARG_PTR, ab), 1'b0);
        send_op(make_op(OP_LD, PE_ID, 1'b0, REG_ARG_END, ab + 8 * arg_words.size()), 1'b0);
        send_op(make_op(OP_LD, PE_ID, 1'b0, REG_NNZ, 40'(nnz)), 1'b0);
        build_model(nnz);
        got_row.delete();
        got_col.delete();
        send_op(make_op(OP_STEADY, PE_ID, 1'b0, 8'd0, '0), 1'b0);
        wait_busy(1'b1);
    endtask

    task automatic run_stream(input logic [ADDR_W-1:0] cb, input logic [ADDR_W-1:0] ab,
                              input int nnz);
        start_stream(cb, ab, nnz);
        wait_busy(1'b0);
        assert (got_row.size() == exp_row.size())
            else fail($sformatf("Error: push count got %h expected %h",
                                got_row.size(), exp_row.size()));
        foreach (exp_row[i]) begin
            assert (got_row[i] == exp_row[i] && got_col[i] == exp_col[i])
                else fail($sformatf("Error: row/col got %h/%h expected %h/%h",
                                    got_row[i], got_col[i], exp_row[i], exp_col[i]));
        end
    endtask

    task automatic test_registers();
        logic [39:0] v;
        for (int r = 0; r < 5; r++) begin
            v = {$urandom, 8'($urandom)};
            send_op(make_op(OP_LD, PE_ID, 1'b0, 8'(r), v), 1'b0);
            check_read(make_op(OP_READ, PE_ID, 1'b0, 8'(r), '0),
                       make_op(OP_RETURN, PE_ID, 1'b0, 8'(r), v));
        end
        // broadcast write then a write for another PE that must be ignored
        send_op(make_op(OP_LD, 0, 1'b1, REG_NNZ, 40'h12_3456_789a), 1'b0);
        send_op(make_op(OP_LD, 5, 1'b0, REG_NNZ, 40'h0f_0f0f_0f0f), 1'b0);
        check_read(make_op(OP_READ, PE_ID, 1'b0, REG_NNZ, '0),
                   make_op(OP_RETURN, PE_ID, 1'b0, REG_NNZ, 40'h12_3456_789a));
        check_read(make_op(OP_READ, 5, 1'b0, REG_NNZ, '0), '0);
        check_read(make_op(OP_READ, PE_ID, 1'b0, 8'd7, '0), '0);
    endtask

    task automatic test_run_control();
        check_quiet(5);
        gen_stream(2, 1'b0);
        run_stream(CODE_BASE, ARG_BASE, tok_pushes);
        check_quiet(5);
    endtask

    task automatic test_constant_tokens();
        gen_stream(6, 1'b0);
        run_stream(CODE_BASE, ARG_BASE, tok_pushes);
    endtask

    task automatic test_range_tokens();
        gen_stream(10, 1'b1);
        run_stream(CODE_BASE, ARG_BASE, tok_pushes);
    endtask

    task automatic test_limits();
        gen_stream(8, 1'b1);
        run_stream(CODE_BASE, ARG_BASE, tok_pushes / 2);
        mem_stall_en = 1'b1;
        idx_stall_en = 1'b1;
        gen_stream(12, 1'b1);
        run_stream(CODE_BASE, ARG_BASE, tok_pushes);
        mem_stall_en = 1'b0;
        idx_stall_en = 1'b0;
    endtask

    task automatic test_soft_reset();
        int n;
        gen_stream(20, 1'b0);
        start_stream(CODE_BASE, ARG_BASE, tok_pushes);
        n = 0;
        while (got_row.size() < 4) begin
            @(posedge clk);
            #1;
            n++;
            assert (n < TIMEOUT) else fail("no index pushes before the soft reset");
        end
        send_op(make_op(OP_RST, PE_ID, 1'b0, 8'd0, '0), 1'b1);
        @(posedge clk);
        #1;
        check_quiet(10);
        assert (row == '0 && col == '1)
            else fail($sformatf("Error: row/col got %h/%h expected %h/%h",
                                row, col, 32'h0, 32'hffff_ffff));
        gen_stream(6, 1'b1);
        run_stream(CODE_BASE + 40'h8000, ARG_BASE + 40'h8000, tok_pushes);
    endtask

    initial begin
        void'($urandom(32'hde1fdd58));
        rst = 1'b1;
        op_in = '0;
        req_mem_stall = 1'b0;
        rsp_mem_push = 1'b0;
        rsp_mem_tag = TAG_CODE;
        rsp_mem_q = '0;
        stall_index = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        test_run_control();
        test_registers();
        test_constant_tokens();
        test_range_tokens();
        test_limits();
        test_soft_reset();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== verilog.f ====
design/spmv_cmd_pkg.sv
design/spmv_stream_pkg.sv
design/reg_if.sv
design/op_decoder.sv
design/stream_fetcher.sv
design/mem_arbiter.sv
design/word_fifo.sv
design/bit_unpacker.sv
design/index_accumulator.sv
design/spmv_decoder_top.sv
sim/spmv_decoder_props.sv
sim/spmv_decoder_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module spmv_decoder_tb -o spmv_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/spmv_sim > sim.log 2>&1
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 || grep -q "ALL TESTS PASSED" sim.log || exit 1
